//--- include/cordic_consts.svh
`ifndef CORDIC_CONSTS_SVH
`define CORDIC_CONSTS_SVH

// Width of x, y, z and of the sine and cosine results
`define CORDIC_WIDTH 16

// Number of micro-rotation stages in the pipeline
`define CORDIC_STAGES 16

// Entries in each of the input and output FIFOs
`define FIFO_DEPTH 32

// Fixed-point constants with 14 fraction bits
`define CORDIC_K 16'h26DD          // Inverse CORDIC gain, starting x
`define CORDIC_PI 32'hC910         // Pi
`define CORDIC_HALF_PI 32'h6488    // Pi over two
`define CORDIC_TWO_PI 32'h19220    // Two pi

`endif

//--- design/cordic_pkg.sv
`include "cordic_consts.svh"

package cordic_pkg;

    // Input angle in radians, twice the sample width so several turns fit
    typedef logic signed [2*`CORDIC_WIDTH-1:0] angle_t;

    // One of x, y, z or a sine or cosine result
    typedef logic signed [`CORDIC_WIDTH-1:0] sample_t;

    // Shift amount of a stage, which is also its index in the chain
    typedef logic [3:0] stage_idx_t;

    // Range reduction FSM
    typedef enum logic [1:0] {
        IDLE,     // Waiting for an angle in the input FIFO
        WRAP,     // Adding or subtracting two pi until within plus or minus pi
        ISSUE     // Folding into the right half plane and loading stage 0
    } reduce_state_t;

endpackage

//--- design/sync_fifo.sv
`timescale 1ns/1ps

`include "cordic_consts.svh"

module sync_fifo #(
    parameter int WIDTH = 16,
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] din,
    input  logic             wr_en,
    output logic             full,
    output logic [WIDTH-1:0] dout,
    input  logic             rd_en,
    output logic             empty
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]  mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_wr;
    logic              do_rd;

    assign full = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    assign do_wr = wr_en && !full;     // Writes into a full FIFO are dropped
    assign do_rd = rd_en && !empty;    // Reads from an empty FIFO are ignored

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither leave the level unchanged
            endcase
        end
    end

    // Storage and the read register
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rd_ptr];    // Head shows up on dout one cycle after the strobe
        end
    end

endmodule

//--- design/cordic_stage.sv
`timescale 1ns/1ps

module cordic_stage
    import cordic_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    input  stage_idx_t k,
    input  sample_t    c,
    input  sample_t    x_in,
    input  sample_t    y_in,
    input  sample_t    z_in,
    input  logic       valid_in,
    output sample_t    x_out,
    output sample_t    y_out,
    output sample_t    z_out,
    output logic       valid_out
);

    sample_t x_shift;
    sample_t y_shift;
    logic    rotate_pos;

    assign x_shift = x_in >>> k;      // Arithmetic shift keeps the sign
    assign y_shift = y_in >>> k;
    assign rotate_pos = !z_in[$bits(sample_t)-1];    // Residual angle is zero or positive

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else if (enable) begin
            valid_out <= valid_in;
        end
    end

    // Payload moves only with the valid, and holds while stalled
    always_ff @(posedge clk) begin
        if (enable) begin
            if (rotate_pos) begin
                x_out <= x_in - y_shift;
                y_out <= y_in + x_shift;
                z_out <= z_in - c;
            end else begin
                x_out <= x_in + y_shift;
                y_out <= y_in - x_shift;
                z_out <= z_in + c;
            end
        end
    end

endmodule

//--- design/cordic.sv
`timescale 1ns/1ps

`include "cordic_consts.svh"

module cordic
    import cordic_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  angle_t  radians_dout,
    output logic    radians_rd_en,
    input  logic    radians_empty,
    output sample_t sin_out_din,
    output logic    sin_wr_en,
    input  logic    sin_full,
    output sample_t cos_out_din,
    output logic    cos_wr_en,
    input  logic    cos_full
);

    localparam int NSTAGES = `CORDIC_STAGES;

    localparam sample_t K = `CORDIC_K;
    localparam angle_t PI = `CORDIC_PI;
    localparam angle_t HALF_PI = `CORDIC_HALF_PI;
    localparam angle_t TWO_PI = `CORDIC_TWO_PI;

    // Arctangent of 2^-i for each stage
    localparam sample_t ATAN_TABLE [NSTAGES] = '{
        16'h3243, 16'h1DAC, 16'h0FAD, 16'h07F5,
        16'h03FE, 16'h01FF, 16'h00FF, 16'h007F,
        16'h003F, 16'h001F, 16'h000F, 16'h0007,
        16'h0003, 16'h0001, 16'h0000, 16'h0000
    };

    reduce_state_t state;
    logic          load_pending;
    angle_t        angle_r;
    angle_t        wrap_angle;
    angle_t        fold_angle;
    sample_t       x_start;
    logic          stall;

    sample_t x_pipe [NSTAGES+1];
    sample_t y_pipe [NSTAGES+1];
    sample_t z_pipe [NSTAGES+1];
    logic    valid_pipe [NSTAGES+1];

    // Hold the whole chain while a finished result cannot be written
    assign stall = valid_pipe[NSTAGES] && (sin_full || cos_full);

    assign radians_rd_en = (state == IDLE) && !radians_empty;

    // The FIFO data arrives one cycle after the strobe, so the first WRAP cycle takes it directly
    assign wrap_angle = load_pending ? radians_dout : angle_r;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            load_pending <= 1'b0;
        end else begin
            load_pending <= radians_rd_en;
            case (state)
                IDLE: begin
                    if (radians_rd_en) begin
                        state <= WRAP;
                    end
                end
                WRAP: begin
                    if (wrap_angle <= PI && wrap_angle >= -PI) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (!stall) begin
                        state <= IDLE;    // Stage 0 takes the angle this cycle
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // One turn of two pi per cycle until the angle lies in minus pi to plus pi
    always_ff @(posedge clk) begin
        if (state == WRAP) begin
            if (wrap_angle > PI) begin
                angle_r <= wrap_angle - TWO_PI;
            end else if (wrap_angle < -PI) begin
                angle_r <= wrap_angle + TWO_PI;
            end else begin
                angle_r <= wrap_angle;
            end
        end
    end

    // A start vector of minus K turns the rotation by pi, which undoes the fold
    always_comb begin
        fold_angle = angle_r;
        x_start = K;
        if (angle_r > HALF_PI) begin
            fold_angle = angle_r - PI;
            x_start = -K;
        end else if (angle_r < -HALF_PI) begin
            fold_angle = angle_r + PI;
            x_start = -K;
        end
    end

    assign x_pipe[0] = x_start;
    assign y_pipe[0] = '0;
    assign z_pipe[0] = fold_angle[$bits(sample_t)-1:0];
    assign valid_pipe[0] = (state == ISSUE) && !stall;

    for (genvar i = 0; i < NSTAGES; i++) begin : g_stage
        cordic_stage u_stage (
            .clk       (clk),
            .reset     (reset),
            .enable    (!stall),
            .k         (stage_idx_t'(i)),
            .c         (ATAN_TABLE[i]),
            .x_in      (x_pipe[i]),
            .y_in      (y_pipe[i]),
            .z_in      (z_pipe[i]),
            .valid_in  (valid_pipe[i]),
            .x_out     (x_pipe[i+1]),
            .y_out     (y_pipe[i+1]),
            .z_out     (z_pipe[i+1]),
            .valid_out (valid_pipe[i+1])
        );
    end

    // Sine is y and cosine is x, written together as the last stage hands over
    assign sin_out_din = y_pipe[NSTAGES];
    assign cos_out_din = x_pipe[NSTAGES];
    assign sin_wr_en = valid_pipe[NSTAGES] && !stall;
    assign cos_wr_en = valid_pipe[NSTAGES] && !stall;

endmodule

//--- design/cordic_top.sv
`timescale 1ns/1ps

module cordic_top
    import cordic_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  angle_t  angle_din,
    input  logic    angle_wr_en,
    output logic    angle_full,
    output sample_t sin_dout,
    input  logic    sin_rd_en,
    output logic    sin_empty,
    output sample_t cos_dout,
    input  logic    cos_rd_en,
    output logic    cos_empty
);

    angle_t  angle_dout;
    logic    angle_rd_en;
    logic    angle_empty;
    sample_t sin_din;
    logic    sin_wr_en;
    logic    sin_full;
    sample_t cos_din;
    logic    cos_wr_en;
    logic    cos_full;

    // Angles from the producer
    sync_fifo #(
        .WIDTH ($bits(angle_t))
    ) u_angle_fifo (
        .clk   (clk),
        .reset (reset),
        .din   (angle_din),
        .wr_en (angle_wr_en),
        .full  (angle_full),
        .dout  (angle_dout),
        .rd_en (angle_rd_en),
        .empty (angle_empty)
    );

    cordic u_cordic (
        .clk           (clk),
        .reset         (reset),
        .radians_dout  (angle_dout),
        .radians_rd_en (angle_rd_en),
        .radians_empty (angle_empty),
        .sin_out_din   (sin_din),
        .sin_wr_en     (sin_wr_en),
        .sin_full      (sin_full),
        .cos_out_din   (cos_din),
        .cos_wr_en     (cos_wr_en),
        .cos_full      (cos_full)
    );

    sync_fifo #(
        .WIDTH ($bits(sample_t))
    ) u_sin_fifo (
        .clk   (clk),
        .reset (reset),
        .din   (sin_din),
        .wr_en (sin_wr_en),
        .full  (sin_full),
        .dout  (sin_dout),
        .rd_en (sin_rd_en),
        .empty (sin_empty)
    );

    sync_fifo #(
        .WIDTH ($bits(sample_t))
    ) u_cos_fifo (
        .clk   (clk),
        .reset (reset),
        .din   (cos_din),
        .wr_en (cos_wr_en),
        .full  (cos_full),
        .dout  (cos_dout),
        .rd_en (cos_rd_en),
        .empty (cos_empty)
    );

endmodule

//--- tb/cordic_checker.sv
`timescale 1ns/1ps

module cordic_checker
    import cordic_pkg::*;
#(
    parameter int MAX_TESTS = 64
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    sin_rd_en,
    input  logic    sin_empty,
    input  sample_t sin_dout,
    input  logic    cos_rd_en,
    input  logic    cos_empty,
    input  sample_t cos_dout,
    input  int      num_tests,
    input  int      num_results,
    input  angle_t  exp_angle [MAX_TESTS],
    input  sample_t exp_sin [MAX_TESTS],
    input  sample_t exp_cos [MAX_TESTS],
    output int      received,
    output int      fail_count,
    output logic    done
);

    logic sin_pop;
    logic cos_pop;
    logic pending;

    assign sin_pop = sin_rd_en && !sin_empty;    // Same condition the FIFO uses to pop
    assign cos_pop = cos_rd_en && !cos_empty;
    assign done = (num_results > 0) && (received >= num_results);

    always @(posedge clk or posedge reset) begin
        int  idx;
        logic bad;
        if (reset) begin
            pending <= 1'b0;
            received <= 0;
            fail_count <= 0;
        end else begin
            pending <= sin_pop;
            if (sin_pop != cos_pop) begin
                $display("Sine and cosine FIFOs popped out of step at %0t", $time);
                fail_count <= fail_count + 1;
            end
            if (pending) begin    // Data of the read in the last cycle is on dout now
                bad = 1'b0;
                if (received >= num_results) begin
                    $display("Extra result beyond the %0d expected at %0t", num_results, $time);
                    bad = 1'b1;
                end else begin
                    idx = received % num_tests;
                    if (sin_dout !== exp_sin[idx]) begin
                        $display("FAIL t=%0t sin_dout got %h expected %h", $time, sin_dout,
                                 exp_sin[idx]);
                        bad = 1'b1;
                    end
                    if (cos_dout !== exp_cos[idx]) begin
                        $display("FAIL t=%0t cos_dout got %h expected %h", $time, cos_dout,
                                 exp_cos[idx]);
                        bad = 1'b1;
                    end
                    if (!bad) begin
                        $display("test %0d angle %h sin %h cos %h ok", received, exp_angle[idx],
                                 sin_dout, cos_dout);
                    end
                end
                if (bad) begin
                    fail_count <= fail_count + 1;
                end
                received <= received + 1;
            end
        end
    end

endmodule

//--- tb/cordic_tb.sv
`timescale 1ns/1ps

module cordic_tb
    import cordic_pkg::*;
();

    localparam int MAX_TESTS = 64;
    localparam int PASSES = 2;          // The list is played twice so the output FIFOs fill
    localparam int CLK_PERIOD = 4;
    localparam int HOLD_OFF = 400;      // Initial consumer stall in cycles

    logic    clk;
    logic    reset;
    angle_t  angle_din;
    logic    angle_wr_en;
    logic    angle_full;
    sample_t sin_dout;
    logic    sin_rd_en;
    logic    sin_empty;
    sample_t cos_dout;
    logic    cos_rd_en;
    logic    cos_empty;

    angle_t  exp_angle [MAX_TESTS];
    sample_t exp_sin [MAX_TESTS];
    sample_t exp_cos [MAX_TESTS];
    int      num_tests;
    int      num_results;
    int      received;
    int      fail_count;
    int      tb_errors;
    int      stall_cycles;
    logic    done;
    logic    loaded;

    cordic_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .angle_din  (angle_din),
        .angle_wr_en(angle_wr_en),
        .angle_full (angle_full),
        .sin_dout   (sin_dout),
        .sin_rd_en  (sin_rd_en),
        .sin_empty  (sin_empty),
        .cos_dout   (cos_dout),
        .cos_rd_en  (cos_rd_en),
        .cos_empty  (cos_empty)
    );

    cordic_checker #(
        .MAX_TESTS (MAX_TESTS)
    ) u_checker (
        .clk         (clk),
        .reset       (reset),
        .sin_rd_en   (sin_rd_en),
        .sin_empty   (sin_empty),
        .sin_dout    (sin_dout),
        .cos_rd_en   (cos_rd_en),
        .cos_empty   (cos_empty),
        .cos_dout    (cos_dout),
        .num_tests   (num_tests),
        .num_results (num_results),
        .exp_angle   (exp_angle),
        .exp_sin     (exp_sin),
        .exp_cos     (exp_cos),
        .received    (received),
        .fail_count  (fail_count),
        .done        (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic load_vectors();
        int          fd;
        string       line;
        logic [31:0] a;
        logic [15:0] s;
        logic [15:0] c;
        fd = $fopen("tb/cordic_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tb/cordic_input.txt");
            tb_errors++;
            return;
        end
        while (!$feof(fd) && num_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%h %h %h", a, s, c) == 3) begin    // Comment lines are skipped
                exp_angle[num_tests] = a;
                exp_sin[num_tests] = s;
                exp_cos[num_tests] = c;
                num_tests++;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_idle_flags();
        repeat (5) begin
            @(posedge clk);
            if (!sin_empty || !cos_empty || angle_full) begin
                $display("FIFO flags wrong after reset at %0t", $time);
                tb_errors++;
            end
        end
    endtask

    task automatic write_angles();
        for (int p = 0; p < PASSES; p++) begin
            for (int i = 0; i < num_tests; i++) begin
                angle_din <= exp_angle[i];
                angle_wr_en <= 1'b1;
                @(posedge clk);
                while (angle_full) begin    // Held until the FIFO accepts it
                    @(posedge clk);
                end
            end
        end
        angle_wr_en <= 1'b0;
    endtask

    // Consumer pops sine and cosine together when a random draw allows it
    always @(posedge clk or posedge reset) begin
        logic pop_ok;
        if (reset) begin
            sin_rd_en <= 1'b0;
            cos_rd_en <= 1'b0;
            stall_cycles <= 0;
        end else if (stall_cycles < HOLD_OFF) begin
            stall_cycles <= stall_cycles + 1;
        end else begin
            pop_ok = !sin_empty && !cos_empty && ($urandom_range(2, 0) == 0);
            sin_rd_en <= pop_ok;
            cos_rd_en <= pop_ok;
        end
    end

    initial begin
        wait (loaded);
        #((200 * num_results + 1000) * CLK_PERIOD);
        $display("Timeout with %0d of %0d results received", received, num_results);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h4b45_aaf5));
        clk = 1'b0;
        reset = 1'b1;
        angle_din = '0;
        angle_wr_en = 1'b0;
        sin_rd_en = 1'b0;
        cos_rd_en = 1'b0;
        num_tests = 0;
        num_results = 0;
        tb_errors = 0;
        loaded = 1'b0;
        load_vectors();
        num_results = num_tests * PASSES;
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        check_idle_flags();
        if (num_tests > 0) begin
            write_angles();
            wait (done);
        end
        repeat (50) @(posedge clk);
        if (!sin_empty || !cos_empty || received != num_results) begin
            $display("Result count wrong, %0d received for %0d angles", received, num_results);
            tb_errors++;
        end
        $display("tests %0d passed %0d failed %0d", num_results,
                 num_results - fail_count, fail_count + tb_errors);
        if (fail_count == 0 && tb_errors == 0 && num_tests > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- tb/cordic_input.txt
# Columns: angle (32-bit, 14 fraction bits), expected sine, expected cosine (16-bit), hex
# Expected values follow the bit-exact 16-stage CORDIC with two pi wrap and half pi fold
00000000 0002 3FFF
00006488 4002 FFFF
FFFF9B78 C003 FFFB
0000C910 0003 BFFC
FFFF36F0 0003 BFFC
00019220 0002 3FFF
FFFE6DE0 0002 3FFF
00032440 0002 3FFF
00025B30 0003 BFFC
FFFDA4D0 0003 BFFC
0003ED50 0003 BFFC
00012D98 C003 FFFB
FFFED268 4002 FFFF
0001F6A8 4002 FFFF
FFFE0958 C003 FFFB
00051AE8 4002 FFFF
FFFC7738 C003 FFFB
00000000 0002 3FFF
0000C910 0003 BFFC
00006488 4002 FFFF
FFFF9B78 C003 FFFB
FFFF36F0 0003 BFFC
00032440 0002 3FFF
0003ED50 0003 BFFC
00012D98 C003 FFFB
FFFED268 4002 FFFF
00051AE8 4002 FFFF
00000000 0002 3FFF

//--- cordic_top.f
+incdir+include
design/cordic_pkg.sv
design/sync_fifo.sv
design/cordic_stage.sv
design/cordic.sv
design/cordic_top.sv
tb/cordic_checker.sv
tb/cordic_tb.sv

//--- Makefile
TOP := cordic_tb
SRCS := $(filter-out +%,$(shell cat cordic_top.f)) include/cordic_consts.svh

.PHONY: all run clean

all: obj_dir/V$(TOP)

obj_dir/V$(TOP): $(SRCS) cordic_top.f tb/cordic_input.txt
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f cordic_top.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
